// File: pim_ctrl_top.f
+incdir+.
pim_ctrl_pkg.sv
pim_ctrl_fsm.sv
pim_exec_timer.sv
pim_row_drive.sv
pim_bus_readback.sv
pim_ctrl_top.sv
tb_pim_ctrl_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_pim_ctrl_top -f pim_ctrl_top.f -o sim_pim_ctrl
./obj_dir/sim_pim_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// File: tb_pim_ctrl_top.sv
`include "pim_ctrl_config.svh"

module tb_pim_ctrl_top;
    import pim_ctrl_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int NUM_PULSE_OPS = 3;
    localparam int OP_OVERHEAD   = 16;                      // session setup plus polling
    localparam int PULSE_OP_MAX  = 6 * (20 + 1) + OP_OVERHEAD;
    localparam int WATCHDOG_CYCLES = 2 * NUM_PULSE_OPS * PULSE_OP_MAX
        + 2 * (`PIM_READ_CYCLES + OP_OVERHEAD)
        + (`PIM_PAR_CYCLES + `PIM_OUT_DELAY + OP_OVERHEAD)
        + (`PIM_LOAD_BEATS + OP_OVERHEAD) + 100;

    logic        clk_i, rst_ni;
    logic [31:0] address_i, data_i, out_buf_data_i;
    logic [31:0] data_o, input_data_o;
    logic        pim_en_o, in_buf_write_o, in_buf_read_o;
    logic        buf_read_en_o, shift_counter_en_o, load_en_o;
    logic [2:0]  pim_mode_o;
    exec_cnt_t   exec_cnt_o;
    row_addr_t   row_addr7_o;
    col_addr_t   col_addr9_o;
    load_cnt_t   load_cnt_o;

    // what the running operation should show
    logic [2:0]  exp_mode;
    row_addr_t   exp_row;
    col_addr_t   exp_col;
    logic [31:0] exp_data;
    logic [31:0] lcg_state = 32'd35717;

    int en_hi = 0, load_hi = 0, bursts = 0, writes = 0;
    int reads = 0, strobes = 0, shifts = 0, since_en = 1000;
    int base_en, base_load, base_bursts, base_writes, base_reads, base_strobes, base_shifts;
    logic        en_d1 = 1'b0, load_d1 = 1'b0, load_d2 = 1'b0;
    logic [31:0] addr_d1 = '0, obuf_d1 = '0;

    pim_ctrl_top uut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("error at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = next_rand();
        return lo + int'(r[23:8] % 16'(hi - lo + 1));
    endfunction

    // enable cycles an operation must produce
    function automatic int expected_enables(input logic [2:0] mode, input int width, input int count);
        case (mode)
            MODE_ERASE, MODE_PROGRAM: return width * count;
            MODE_READ:                return `PIM_READ_CYCLES;
            MODE_PARALLEL:            return `PIM_PAR_CYCLES;
            MODE_LOAD:                return `PIM_LOAD_BEATS;
            default:                  return 0;
        endcase
    endfunction

    function automatic int expected_bursts(input logic [2:0] mode, input int count);
        case (mode)
            MODE_ERASE, MODE_PROGRAM:          return count;
            MODE_READ, MODE_PARALLEL, MODE_LOAD: return 1;
            default:                           return 0;
        endcase
    endfunction

    // beats still to come after the current one, fixed-length operations only
    function automatic int remaining_count(input logic [2:0] mode, input int beats_done);
        case (mode)
            MODE_READ, MODE_PARALLEL, MODE_LOAD: return expected_enables(mode, 0, 0) - beats_done;
            default:                             return 0;
        endcase
    endfunction

    task automatic bus_cycle(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_i);
        #1;
        address_i      = addr;
        data_i         = data;
        out_buf_data_i = next_rand();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) bus_cycle(32'd0, 32'd0);
    endtask

    task automatic read_status(output logic [31:0] status);
        bus_cycle(`PIM_STATUS_ADDR, 32'd0);
        bus_cycle(32'd0, 32'd0);
        status = data_o;
    endtask

    // poll busy until the controller is free again
    task automatic wait_done(input int quiet);
        logic [31:0] status;
        read_status(status);
        check_equal(status, 32'd3, "status while operation runs");
        idle_cycles(quiet);
        do begin
            read_status(status);
            check_equal(32'(status[31:1]), 32'd1, "status valid bit");
        end while (status[0]);
    endtask

    task automatic snapshot_counts();
        base_en      = en_hi;
        base_load    = load_hi;
        base_bursts  = bursts;
        base_writes  = writes;
        base_reads   = reads;
        base_strobes = strobes;
        base_shifts  = shifts;
    endtask

    task automatic end_op(input logic [2:0] mode, input int width, input int count);
        int exp_hi;
        int par;
        exp_hi = expected_enables(mode, width, count);
        par    = (mode == MODE_PARALLEL) ? 1 : 0;
        check_equal(en_hi - base_en, (mode == MODE_LOAD) ? 0 : exp_hi, "pim_en_o high cycles");
        check_equal(load_hi - base_load, (mode == MODE_LOAD) ? exp_hi : 0, "load_en_o high cycles");
        check_equal(bursts - base_bursts, expected_bursts(mode, count), "enable bursts");
        check_equal(writes - base_writes, par, "in_buf_write_o pulses");
        check_equal(reads - base_reads, par * `PIM_PAR_CYCLES, "in_buf_read_o high cycles");
        check_equal(strobes - base_strobes, par, "buf_read_en_o pulses");
        check_equal(shifts - base_shifts, par, "shift_counter_en_o pulses");
    endtask

    task automatic run_op(input logic [2:0] mode, input logic [31:0] addr,
                          input logic [31:0] data, input int width, input int count);
        snapshot_counts();
        exp_mode = mode;
        exp_row  = addr[15:9];
        exp_col  = (mode == MODE_ERASE) ? '0 : addr[8:0];
        exp_data = data;
        bus_cycle(`PIM_STATUS_ADDR, 32'd0);
        bus_cycle(`PIM_MODE_ADDR, 32'(mode));
        if (mode != MODE_LOAD) begin
            bus_cycle(addr, data);
        end
        wait_done((mode == MODE_LOAD) ? `PIM_LOAD_BEATS : 0);
        end_op(mode, width, count);
    endtask

    // compare process sampled mid-cycle
    always @(negedge clk_i) begin
        if (pim_en_o) begin
            en_hi++;
            since_en = 0;
            check_equal(32'(pim_mode_o), 32'(exp_mode), "pim_mode_o during enable");
            check_equal(32'(row_addr7_o), 32'(exp_row), "row_addr7_o");
            check_equal(32'(col_addr9_o), 32'(exp_col), "col_addr9_o");
            check_equal(32'(in_buf_read_o), 32'(exp_mode == MODE_PARALLEL), "in_buf_read_o");
            check_equal(32'(exec_cnt_o), 32'(remaining_count(exp_mode, en_hi - base_en)),
                        "exec_cnt_o");
        end else if (since_en < 1000) begin
            since_en++;
        end
        if (in_buf_read_o) reads++;
        if (load_en_o) begin
            load_hi++;
            check_equal(32'(load_cnt_o), 32'(remaining_count(exp_mode, load_hi - base_load)),
                        "load_cnt_o");
        end
        if ((pim_en_o || load_en_o) && !en_d1) bursts++;
        en_d1 = pim_en_o || load_en_o;
        if (in_buf_write_o) begin
            writes++;
            check_equal(input_data_o, exp_data, "input_data_o");
        end
        if (buf_read_en_o) begin
            strobes++;
            check_equal(32'(since_en <= 4), 32'd1, "output strobe late after last enable");
            check_equal(32'(pim_mode_o), 32'(MODE_PARALLEL), "pim_mode_o in output phase");
        end
        if (shift_counter_en_o) begin
            shifts++;
            check_equal(32'(buf_read_en_o), 32'd1, "shift strobe without buffer read");
        end
        // status cycles are checked by the poll task
        if (addr_d1 != `PIM_STATUS_ADDR) begin
            check_equal(data_o, load_d2 ? obuf_d1 : 32'd0, "data_o read-back");
        end
        load_d2 = load_d1;
        load_d1 = load_en_o;
        addr_d1 = address_i;
        obuf_d1 = out_buf_data_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("TESTS FAILED");
        $fatal(1, "timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    end

    initial begin
        int i, w, c;
        logic [31:0] r, addr, dat;
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        address_i      = '0;
        data_i         = '0;
        out_buf_data_i = '0;
        exp_mode       = MODE_NONE;
        exp_row        = '0;
        exp_col        = '0;
        exp_data       = '0;
        repeat (3) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        @(negedge clk_i);
        check_equal(32'({pim_en_o, pim_mode_o, exec_cnt_o, row_addr7_o, col_addr9_o}), 32'd0,
                    "row-driver outputs after reset");
        check_equal(32'({in_buf_write_o, in_buf_read_o, buf_read_en_o, shift_counter_en_o,
                         load_en_o, load_cnt_o}), 32'd0, "buffer outputs after reset");
        check_equal(data_o, 32'd0, "data_o after reset");
        check_equal(input_data_o, 32'd0, "input_data_o after reset");
        read_status(r);
        check_equal(r, 32'd2, "status when idle");

        for (i = 0; i < NUM_PULSE_OPS; i++) begin
            w    = rand_range(1, 20);
            c    = rand_range(1, 6);
            r    = next_rand();
            addr = {`PIM_OP_REGION, r[19:0]};
            dat  = {10'd0, w[16:0], c[4:0]};
            run_op(MODE_ERASE, addr, dat, w, c);
            w    = rand_range(1, 20);
            c    = rand_range(1, 6);
            r    = next_rand();
            addr = {`PIM_OP_REGION, r[19:0]};
            dat  = {10'd0, w[16:0], c[4:0]};
            run_op(MODE_PROGRAM, addr, dat, w, c);
        end

        r = next_rand();
        run_op(MODE_READ, {`PIM_OP_REGION, r[19:0]}, next_rand(), 0, 0);
        r = next_rand();
        run_op(MODE_PARALLEL, {`PIM_PAR_REGION, r[15:0]}, next_rand(), 0, 0);
        run_op(MODE_LOAD, 32'd0, 32'd0, 0, 0);

        // unused mode codes and a stray access
        snapshot_counts();
        exp_mode = MODE_NONE;
        bus_cycle(`PIM_STATUS_ADDR, 32'd0);
        bus_cycle(`PIM_MODE_ADDR, 32'd4);
        bus_cycle({`PIM_OP_REGION, 20'h00123}, 32'h0000_0041);
        bus_cycle(`PIM_MODE_ADDR, 32'd6);
        bus_cycle({`PIM_OP_REGION, 20'h00123}, 32'h0000_0041);
        bus_cycle(`PIM_MODE_ADDR, 32'(MODE_READ));
        bus_cycle(32'h5000_0246, 32'd0);        // outside the op region
        idle_cycles(10);
        end_op(MODE_NONE, 0, 0);

        // pending read still takes a proper access
        snapshot_counts();
        addr     = {`PIM_OP_REGION, 20'h005A5};
        exp_mode = MODE_READ;
        exp_row  = addr[15:9];
        exp_col  = addr[8:0];
        bus_cycle(addr, 32'd0);
        wait_done(0);
        end_op(MODE_READ, 0, 0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: pim_ctrl_top.sv
module pim_ctrl_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [31:0]              address_i,
    input  logic [31:0]              data_i,
    input  logic [31:0]              out_buf_data_i,
    output logic [31:0]              data_o,
    output logic                     pim_en_o,
    output logic [2:0]               pim_mode_o,
    output pim_ctrl_pkg::exec_cnt_t  exec_cnt_o,
    output pim_ctrl_pkg::row_addr_t  row_addr7_o,
    output pim_ctrl_pkg::col_addr_t  col_addr9_o,
    output logic [31:0]              input_data_o,
    output logic                     in_buf_write_o,
    output logic                     in_buf_read_o,
    output logic                     buf_read_en_o,
    output logic                     shift_counter_en_o,
    output logic                     load_en_o,
    output pim_ctrl_pkg::load_cnt_t  load_cnt_o
);
    import pim_ctrl_pkg::*;

    pim_mode_e    mode;
    logic         start, finish, enable, busy;
    logic         out_en, out_last, out_done;
    row_addr_t    row;
    col_addr_t    col;
    pulse_width_t pulse_width;
    pulse_count_t pulse_count;
    exec_cnt_t    cnt;
    load_cnt_t    load_cnt;

    assign busy = (mode != MODE_NONE);

    pim_ctrl_fsm u_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .address_i      (address_i),
        .data_i         (data_i),
        .finish_i       (finish),
        .out_done_i     (out_done),
        .mode_o         (mode),
        .start_o        (start),
        .row_o          (row),
        .col_o          (col),
        .pulse_width_o  (pulse_width),
        .pulse_count_o  (pulse_count),
        .in_buf_write_o (in_buf_write_o),
        .input_data_o   (input_data_o)
    );

    pim_exec_timer u_timer (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .mode_i        (mode),
        .start_i       (start),
        .pulse_width_i (pulse_width),
        .pulse_count_i (pulse_count),
        .enable_o      (enable),
        .cnt_o         (cnt),
        .load_cnt_o    (load_cnt),
        .finish_o      (finish),
        .out_en_o      (out_en),
        .out_last_o    (out_last),
        .out_done_o    (out_done)
    );

    pim_row_drive u_row_drive (
        .mode_i             (mode),
        .enable_i           (enable),
        .row_i              (row),
        .col_i              (col),
        .cnt_i              (cnt),
        .load_cnt_i         (load_cnt),
        .out_en_i           (out_en),
        .out_last_i         (out_last),
        .pim_en_o           (pim_en_o),
        .pim_mode_o         (pim_mode_o),
        .exec_cnt_o         (exec_cnt_o),
        .row_addr7_o        (row_addr7_o),
        .col_addr9_o        (col_addr9_o),
        .in_buf_read_o      (in_buf_read_o),
        .load_en_o          (load_en_o),
        .load_cnt_o         (load_cnt_o),
        .buf_read_en_o      (buf_read_en_o),
        .shift_counter_en_o (shift_counter_en_o)
    );

    pim_bus_readback u_readback (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .address_i      (address_i),
        .busy_i         (busy),
        .load_en_i      (load_en_o),
        .out_buf_data_i (out_buf_data_i),
        .data_o         (data_o)
    );

endmodule

// File: pim_bus_readback.sv
`include "pim_ctrl_config.svh"

module pim_bus_readback (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic [31:0] address_i,
    input  logic        busy_i,
    input  logic        load_en_i,
    input  logic [31:0] out_buf_data_i,
    output logic [31:0] data_o
);

    logic load_q;   // buffer word valid one cycle after load_en

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            load_q <= 1'b0;
            data_o <= '0;
        end else begin
            load_q <= load_en_i;
            if (address_i == `PIM_STATUS_ADDR) begin
                data_o <= {30'b0, 1'b1, busy_i};    // valid, busy
            end else if (load_q) begin
                data_o <= out_buf_data_i;
            end else begin
                data_o <= '0;
            end
        end
    end

endmodule

// File: pim_row_drive.sv
module pim_row_drive (
    input  pim_ctrl_pkg::pim_mode_e  mode_i,
    input  logic                     enable_i,
    input  pim_ctrl_pkg::row_addr_t  row_i,
    input  pim_ctrl_pkg::col_addr_t  col_i,
    input  pim_ctrl_pkg::exec_cnt_t  cnt_i,
    input  pim_ctrl_pkg::load_cnt_t  load_cnt_i,
    input  logic                     out_en_i,
    input  logic                     out_last_i,
    output logic                     pim_en_o,
    output logic [2:0]               pim_mode_o,
    output pim_ctrl_pkg::exec_cnt_t  exec_cnt_o,
    output pim_ctrl_pkg::row_addr_t  row_addr7_o,
    output pim_ctrl_pkg::col_addr_t  col_addr9_o,
    output logic                     in_buf_read_o,
    output logic                     load_en_o,
    output pim_ctrl_pkg::load_cnt_t  load_cnt_o,
    output logic                     buf_read_en_o,
    output logic                     shift_counter_en_o
);
    import pim_ctrl_pkg::*;

    always_comb begin
        pim_en_o           = 1'b0;
        pim_mode_o         = '0;
        exec_cnt_o         = '0;
        row_addr7_o        = '0;
        col_addr9_o        = '0;
        in_buf_read_o      = 1'b0;
        load_en_o          = 1'b0;
        load_cnt_o         = '0;
        buf_read_en_o      = 1'b0;
        shift_counter_en_o = 1'b0;
        case (mode_i)
            MODE_ERASE, MODE_PROGRAM, MODE_READ, MODE_PARALLEL: begin
                if (enable_i) begin
                    pim_en_o    = 1'b1;
                    pim_mode_o  = mode_i;
                    row_addr7_o = row_i;
                    if (mode_i != MODE_ERASE) begin     // erase is row-wide
                        col_addr9_o = col_i;
                    end
                    if (mode_i inside {MODE_READ, MODE_PARALLEL}) begin
                        exec_cnt_o = cnt_i;
                    end
                    in_buf_read_o = (mode_i == MODE_PARALLEL);
                end else if (mode_i == MODE_PARALLEL && out_en_i) begin
                    pim_mode_o         = MODE_PARALLEL;   // held through output phase
                    buf_read_en_o      = out_last_i;
                    shift_counter_en_o = out_last_i;
                end
            end
            MODE_LOAD: begin
                if (enable_i) begin
                    load_en_o  = 1'b1;
                    load_cnt_o = load_cnt_i;
                end
            end
            default: begin
                pim_en_o = 1'b0;
            end
        endcase
    end

endmodule

// File: pim_exec_timer.sv
`include "pim_ctrl_config.svh"

module pim_exec_timer (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  pim_ctrl_pkg::pim_mode_e     mode_i,
    input  logic                        start_i,
    input  pim_ctrl_pkg::pulse_width_t  pulse_width_i,
    input  pim_ctrl_pkg::pulse_count_t  pulse_count_i,
    output logic                        enable_o,
    output pim_ctrl_pkg::exec_cnt_t     cnt_o,
    output pim_ctrl_pkg::load_cnt_t     load_cnt_o,
    output logic                        finish_o,
    output logic                        out_en_o,
    output logic                        out_last_o,
    output logic                        out_done_o
);
    import pim_ctrl_pkg::*;

    localparam int unsigned OUT_W = $clog2(`PIM_OUT_DELAY + 1);

    logic             run_q, out_run_q, active;
    logic             beat, done;
    pulse_width_t     pw_q, pw_init_q, pw_cur, pw_reload;
    pulse_count_t     pc_q, pc_cur;
    exec_cnt_t        cnt_cur;
    load_cnt_t        lcnt_cur;
    logic [OUT_W-1:0] out_cnt_q;

    function automatic exec_cnt_t fixed_cycles(pim_mode_e m);
        case (m)
            MODE_READ:     return exec_cnt_t'(`PIM_READ_CYCLES);
            MODE_PARALLEL: return exec_cnt_t'(`PIM_PAR_CYCLES);
            default:       return '0;
        endcase
    endfunction

    // the start cycle already runs the first beat, so enable rises right after start_i
    assign active    = start_i | run_q;
    assign pw_cur    = start_i ? pulse_width_i : pw_q;
    assign pw_reload = start_i ? pulse_width_i : pw_init_q;
    assign pc_cur    = start_i ? pulse_count_i : pc_q;
    assign cnt_cur   = start_i ? fixed_cycles(mode_i) : cnt_o;
    assign lcnt_cur  = (start_i && mode_i == MODE_LOAD) ? load_cnt_t'(`PIM_LOAD_BEATS) : load_cnt_o;

    always_comb begin
        beat = 1'b0;
        done = 1'b0;
        case (mode_i)
            MODE_ERASE, MODE_PROGRAM: begin
                beat = (pc_cur != '0) && (pw_cur != '0);
                done = (pc_cur == '0);
            end
            MODE_READ, MODE_PARALLEL: begin
                beat = (cnt_cur != '0);
                done = !beat;
            end
            MODE_LOAD: begin
                beat = (lcnt_cur != '0);
                done = !beat;
            end
            default: done = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            run_q      <= 1'b0;
            enable_o   <= 1'b0;
            finish_o   <= 1'b0;
            pw_q       <= '0;
            pw_init_q  <= '0;
            pc_q       <= '0;
            cnt_o      <= '0;
            load_cnt_o <= '0;
        end else begin
            enable_o <= active && beat;
            finish_o <= active && done;
            if (start_i) begin
                pw_init_q <= pulse_width_i;
            end
            if (active) begin
                run_q <= !done;
                // width runs out -> one low cycle, then reload for the next pulse
                pw_q  <= (pw_cur != '0) ? pw_cur - 1'b1 : pw_reload;
                pc_q  <= (pw_cur == '0 && pc_cur != '0) ? pc_cur - 1'b1 : pc_cur;
                cnt_o      <= (cnt_cur != '0) ? cnt_cur - 1'b1 : '0;
                load_cnt_o <= (lcnt_cur != '0) ? lcnt_cur - 1'b1 : '0;
            end
        end
    end

    // output phase after a parallel window
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_run_q  <= 1'b0;
            out_cnt_q  <= '0;
            out_en_o   <= 1'b0;
            out_done_o <= 1'b0;
        end else begin
            out_done_o <= 1'b0;
            if (active && done && mode_i == MODE_PARALLEL) begin
                out_run_q <= 1'b1;
                out_cnt_q <= OUT_W'(`PIM_OUT_DELAY);
            end else if (out_run_q) begin
                if (out_cnt_q != '0) begin
                    out_en_o  <= 1'b1;
                    out_cnt_q <= out_cnt_q - 1'b1;
                end else begin
                    out_en_o   <= 1'b0;
                    out_done_o <= 1'b1;
                    out_run_q  <= 1'b0;
                end
            end
        end
    end

    assign out_last_o = out_en_o && (out_cnt_q == '0);

endmodule

// File: pim_ctrl_fsm.sv
`include "pim_ctrl_config.svh"

module pim_ctrl_fsm (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic [31:0]                 address_i,
    input  logic [31:0]                 data_i,
    input  logic                        finish_i,
    input  logic                        out_done_i,
    output pim_ctrl_pkg::pim_mode_e     mode_o,
    output logic                        start_o,
    output pim_ctrl_pkg::row_addr_t     row_o,
    output pim_ctrl_pkg::col_addr_t     col_o,
    output pim_ctrl_pkg::pulse_width_t  pulse_width_o,
    output pim_ctrl_pkg::pulse_count_t  pulse_count_o,
    output logic                        in_buf_write_o,
    output logic [31:0]                 input_data_o
);
    import pim_ctrl_pkg::*;

    pim_state_e state_q, state_d;
    pim_mode_e  mode_q, mode_d;
    logic       start_d;
    logic       op_region, par_region;
    logic       accept, accept_par;

    assign op_region  = (address_i[31:20] == `PIM_OP_REGION);
    assign par_region = (address_i[31:16] == `PIM_PAR_REGION);

    // operation access only counts in the region of the active mode
    assign accept_par = (mode_q == MODE_PARALLEL) && par_region;
    assign accept = (state_q == ST_MODE_READY) && (accept_par ||
        ((mode_q inside {MODE_ERASE, MODE_PROGRAM, MODE_READ}) && op_region));

    always_comb begin
        state_d = state_q;
        mode_d  = mode_q;
        start_d = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (address_i == `PIM_STATUS_ADDR && mode_q == MODE_NONE) begin
                    state_d = ST_WAIT_MODE;
                end
            end
            ST_WAIT_MODE: begin
                if (address_i == `PIM_MODE_ADDR) begin
                    case (data_i[2:0])
                        MODE_ERASE, MODE_PROGRAM, MODE_READ, MODE_PARALLEL: begin
                            mode_d  = pim_mode_e'(data_i[2:0]);
                            state_d = ST_MODE_READY;
                        end
                        MODE_LOAD: begin    // no operation access needed
                            mode_d  = MODE_LOAD;
                            state_d = ST_MODE_EXEC;
                            start_d = 1'b1;
                        end
                        default: begin      // none, 4 and 6 ignored
                            state_d = ST_WAIT_MODE;
                        end
                    endcase
                end
            end
            ST_MODE_READY: begin
                if (accept) begin
                    state_d = ST_MODE_EXEC;
                    start_d = 1'b1;
                end
            end
            ST_MODE_EXEC: begin
                if (finish_i) begin
                    if (mode_q == MODE_PARALLEL) begin
                        state_d = ST_MODE_OUTPUT;
                    end else begin
                        state_d = ST_IDLE;
                        mode_d  = MODE_NONE;
                    end
                end
            end
            ST_MODE_OUTPUT: begin
                if (out_done_i) begin
                    state_d = ST_IDLE;
                    mode_d  = MODE_NONE;
                end
            end
            default: begin
                state_d = ST_IDLE;
                mode_d  = MODE_NONE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q        <= ST_IDLE;
            mode_q         <= MODE_NONE;
            start_o        <= 1'b0;
            in_buf_write_o <= 1'b0;
            input_data_o   <= '0;
        end else begin
            state_q        <= state_d;
            mode_q         <= mode_d;
            start_o        <= start_d;
            in_buf_write_o <= accept && accept_par;
            input_data_o   <= (accept && accept_par) ? data_i : '0;
        end
    end

    // command fields, row [15:9] col [8:0] width [21:5] count [4:0]
    always_ff @(posedge clk_i) begin
        if (accept) begin
            row_o         <= address_i[`PIM_COL_W +: `PIM_ROW_W];
            col_o         <= address_i[`PIM_COL_W-1:0];
            pulse_width_o <= data_i[`PIM_PC_W +: `PIM_PW_W];
            pulse_count_o <= data_i[`PIM_PC_W-1:0];
        end
    end

    assign mode_o = mode_q;

endmodule

// File: pim_ctrl_pkg.sv
`include "pim_ctrl_config.svh"

package pim_ctrl_pkg;

    // operation codes as written to the mode register, 4 and 6 unused
    typedef enum logic [2:0] {
        MODE_NONE     = 3'd0,
        MODE_ERASE    = 3'd1,
        MODE_PROGRAM  = 3'd2,
        MODE_READ     = 3'd3,
        MODE_PARALLEL = 3'd5,
        MODE_LOAD     = 3'd7
    } pim_mode_e;

    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_WAIT_MODE   = 3'd1,
        ST_MODE_READY  = 3'd2,
        ST_MODE_EXEC   = 3'd4,
        ST_MODE_OUTPUT = 3'd5
    } pim_state_e;

    typedef logic [`PIM_ROW_W-1:0]  row_addr_t;
    typedef logic [`PIM_COL_W-1:0]  col_addr_t;

    typedef logic [`PIM_PW_W-1:0]   pulse_width_t;
    typedef logic [`PIM_PC_W-1:0]   pulse_count_t;

    typedef logic [`PIM_CNT_W-1:0]  exec_cnt_t;
    typedef logic [`PIM_LOAD_W-1:0] load_cnt_t;

endpackage

// File: pim_ctrl_config.svh
`ifndef PIM_CTRL_CONFIG_SVH
`define PIM_CTRL_CONFIG_SVH

// bus map
`define PIM_MODE_ADDR    32'h4100_0000
`define PIM_STATUS_ADDR  32'h4300_0000

`define PIM_OP_REGION    12'h400    // address_i[31:20], erase/program/read
`define PIM_PAR_REGION   16'h400F   // address_i[31:16], parallel

// field widths
`define PIM_ROW_W        7
`define PIM_COL_W        9
`define PIM_PW_W         17
`define PIM_PC_W         5
`define PIM_CNT_W        4
`define PIM_LOAD_W       6

// operation lengths in cycles
`define PIM_READ_CYCLES  9
`define PIM_PAR_CYCLES   12
`define PIM_LOAD_BEATS   32
`define PIM_OUT_DELAY    2

`endif
